//--- files.f
+incdir+include
verilog/wb_mem_pkg.sv
verilog/bram_bank.sv
verilog/bram_controller.sv
verilog/cmd_fifo.sv
verilog/host_cmd_port.sv
verilog/wb_master.sv
verilog/wb_mem_top.sv
tb/tb_wb_mem_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the wb_mem_top testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_wb_mem_top
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module "$TOP" \
  --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0

//--- include/wb_mem_tb_tasks.svh
`ifndef WB_MEM_TB_TASKS_SVH
`define WB_MEM_TB_TASKS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_rsp(input string name, input wb_mem_pkg::rsp_t exp,
                         input wb_mem_pkg::rsp_t act);
  if (act !== exp) begin
    $display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, exp, act);
    stop_on_error();
  end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] %0d ns %s: expected %b, got %b", $time, name, exp, act);
    stop_on_error();
  end
endtask

//////////////////////////////////////////////////
// host side driver
//////////////////////////////////////////////////

function automatic wb_mem_pkg::cmd_t make_cmd(input logic write, input logic [31:0] addr,
                                              input logic [1:0] sel, input logic [15:0] wdata);
  wb_mem_pkg::cmd_t c;
  c.write = write;
  c.addr  = addr;
  c.sel   = sel;
  c.wdata = wdata;
  return c;
endfunction

task automatic start_cmd(input wb_mem_pkg::cmd_t c);
  @(posedge wb_clk_i);
  cmd_i     <= c;
  cmd_req_i <= 1'b1;
endtask

task automatic finish_cmd();
  @(negedge wb_clk_i);
  while (!cmd_ack_o) @(negedge wb_clk_i);
  @(posedge wb_clk_i);
  cmd_req_i <= 1'b0;
  @(negedge wb_clk_i);
  while (cmd_ack_o) @(negedge wb_clk_i);
endtask

task automatic issue_cmd(input wb_mem_pkg::cmd_t c);
  exp_q.push_back(model_apply(c));
  start_cmd(c);
  finish_cmd();
endtask

task automatic collect_rsp();
  wb_mem_pkg::rsp_t got;
  @(negedge wb_clk_i);
  while (!rsp_req_o) @(negedge wb_clk_i);
  got = rsp_o;
  check_rsp("rsp_o", exp_q.pop_front(), got);
  @(posedge wb_clk_i);
  rsp_ack_i <= 1'b1;
  @(negedge wb_clk_i);
  while (rsp_req_o) @(negedge wb_clk_i);
  @(posedge wb_clk_i);
  rsp_ack_i <= 1'b0;
endtask

task automatic run_cmd(input logic write, input logic [31:0] addr, input logic [1:0] sel,
                       input logic [15:0] wdata);
  issue_cmd(make_cmd(write, addr, sel, wdata));
  collect_rsp();
endtask

function automatic wb_mem_pkg::cmd_t random_cmd();
  logic [31:0] wr;
  logic [31:0] idx;
  logic [31:0] sel;
  logic [31:0] data;
  wr   = rand_bits(1);
  idx  = rand_bits(4) % used_addr.size();
  sel  = rand_bits(2);
  data = rand_bits(16);
  return make_cmd(wr[0], used_addr[idx], sel[1:0], data[15:0]);
endfunction

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic test_basic_rw();
  logic [31:0] addr [4];
  logic [31:0] off;
  logic [31:0] data;
  @(negedge wb_clk_i);
  check_level("cmd_ack_o", 1'b0, cmd_ack_o);
  check_level("rsp_req_o", 1'b0, rsp_req_o);
  for (int i = 0; i < 4; i++) begin
    off     = rand_bits(11);
    data    = rand_bits(16);
    addr[i] = {20'h0, off[10:0], 1'b0};
    used_addr.push_back(addr[i]);
    run_cmd(1'b1, addr[i], 2'b11, data[15:0]);   // write response, zero data
  end
  for (int i = 0; i < 4; i++) run_cmd(1'b0, addr[i], 2'b11, 16'h0);
endtask

task automatic test_byte_lanes();
  logic [31:0] off;
  logic [31:0] addr;
  logic [31:0] data;
  off  = rand_bits(11);
  addr = {20'h0, off[10:0], 1'b0};
  used_addr.push_back(addr);
  data = rand_bits(16);
  run_cmd(1'b1, addr, 2'b11, data[15:0]);
  data = rand_bits(16);
  run_cmd(1'b1, addr, 2'b01, data[15:0]);     // host high byte only
  run_cmd(1'b0, addr, 2'b11, 16'h0);
  data = rand_bits(16);
  run_cmd(1'b1, addr, 2'b10, data[15:0]);     // host low byte only
  run_cmd(1'b0, addr, 2'b11, 16'h0);
endtask

task automatic test_banks();
  logic [31:0] off;
  logic [31:0] data;
  logic [31:0] a0;
  logic [31:0] a1;
  off = rand_bits(11);
  a0  = {20'h0, off[10:0], 1'b0};
  a1  = a0 | 32'h0000_1000;
  used_addr.push_back(a0);
  used_addr.push_back(a1);
  data = rand_bits(16);
  run_cmd(1'b1, a0, 2'b11, data[15:0]);
  data = rand_bits(16);
  run_cmd(1'b1, a1, 2'b11, data[15:0]);
  run_cmd(1'b0, a0, 2'b11, 16'h0);
  run_cmd(1'b0, a1, 2'b11, 16'h0);
  // same offset past the last bank
  data = rand_bits(16);
  run_cmd(1'b1, a0 | 32'h0000_2000, 2'b11, data[15:0]);
  run_cmd(1'b0, a0 | 32'h0000_2000, 2'b11, 16'h0);
  run_cmd(1'b0, a0 | 32'hffff_f000, 2'b11, 16'h0);
  run_cmd(1'b0, a0, 2'b11, 16'h0);
  run_cmd(1'b0, a1, 2'b11, 16'h0);
endtask

task automatic test_back_pressure();
  wb_mem_pkg::cmd_t c;
  for (int i = 0; i < 8; i++) issue_cmd(random_cmd());
  // both queues hold four now, so a ninth command waits
  c = random_cmd();
  exp_q.push_back(model_apply(c));
  start_cmd(c);
  repeat (10) begin
    @(negedge wb_clk_i);
    check_level("cmd_ack_o", 1'b0, cmd_ack_o);
  end
  collect_rsp();
  finish_cmd();
  while (exp_q.size() > 0) collect_rsp();
  // no response beyond the commands issued
  repeat (4) @(negedge wb_clk_i);
  check_level("rsp_req_o", 1'b0, rsp_req_o);
endtask

`endif

//--- tb/tb_wb_mem_top.sv
`timescale 1ns/10ps

module tb_wb_mem_top;

  localparam int RAM_SIZE_K      = 8;
  localparam int FIFO_DEPTH      = 4;
  localparam int NUM_BANKS       = (RAM_SIZE_K + 3) / 4;   // one per started 4 KB
  localparam int CLK_PERIOD      = 4;
  localparam int TOTAL_CMDS      = 31;                     // all four tests together
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_CMDS + 100;

  logic             wb_clk_i;
  logic             wb_rst_i;
  logic             cmd_req_i;
  wb_mem_pkg::cmd_t cmd_i;
  logic             cmd_ack_o;
  logic             rsp_req_o;
  wb_mem_pkg::rsp_t rsp_o;
  logic             rsp_ack_i;

  logic [31:0] lfsr_state = 32'h14e98068;

  wb_mem_pkg::rsp_t              exp_q[$];                   // in command order
  logic [wb_mem_pkg::DATA_W-1:0] model_mem [int unsigned];   // stored word, by word address
  logic [wb_mem_pkg::ADDR_W-1:0] used_addr[$];               // words written in full

  wb_mem_top #(.RAM_SIZE_K(RAM_SIZE_K), .FIFO_DEPTH(FIFO_DEPTH)) i_wb_mem_top (
    .wb_clk_i  (wb_clk_i),  .wb_rst_i  (wb_rst_i),
    .cmd_req_i (cmd_req_i), .cmd_i     (cmd_i),     .cmd_ack_o (cmd_ack_o),
    .rsp_req_o (rsp_req_o), .rsp_o     (rsp_o),     .rsp_ack_i (rsp_ack_i)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  //////////////////////////////////////////////////
  // random bits and memory model
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    end
    return v;
  endfunction

  function automatic logic [15:0] reverse_word(input logic [15:0] w);
    return {<<{w}};
  endfunction

  // updates the model and returns the response the host should see
  function automatic wb_mem_pkg::rsp_t model_apply(input wb_mem_pkg::cmd_t c);
    wb_mem_pkg::rsp_t r;
    logic [15:0]      stored;
    logic [15:0]      wrev;
    int unsigned      key;
    logic             in_range;
    key         = c.addr >> 1;
    in_range    = (c.addr[31:12] < NUM_BANKS);
    r.was_write = c.write;
    r.rdata     = '0;
    stored      = model_mem.exists(key) ? model_mem[key] : 16'hxxxx;
    if (c.write && in_range) begin
      wrev = reverse_word(c.wdata);
      if (c.sel[0]) stored[7:0] = wrev[7:0];     // stored byte 0
      if (c.sel[1]) stored[15:8] = wrev[15:8];
      model_mem[key] = stored;
    end else if (!c.write && in_range) begin
      r.rdata = reverse_word(stored);
    end
    return r;
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  `include "wb_mem_tb_tasks.svh"

  // handshake rules, sampled away from the driving edge
  logic cmd_ack_q, cmd_req_q, rsp_req_q, rsp_ack_q;

  always @(negedge wb_clk_i) begin
    if (!wb_rst_i) begin
      if (cmd_ack_q && !cmd_ack_o) check_level("cmd_req_i at cmd_ack_o fall", 1'b0, cmd_req_q);
      if (!rsp_req_q && rsp_req_o) check_level("rsp_ack_i at rsp_req_o rise", 1'b0, rsp_ack_q);
    end
    cmd_ack_q = cmd_ack_o;
    cmd_req_q = cmd_req_i;
    rsp_req_q = rsp_req_o;
    rsp_ack_q = rsp_ack_i;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    wb_clk_i  = 1'b0;
    wb_rst_i  = 1'b1;
    cmd_req_i = 1'b0;
    cmd_i     = '0;
    rsp_ack_i = 1'b0;
    repeat (2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    test_basic_rw();
    test_byte_lanes();
    test_banks();
    test_back_pressure();
    @(negedge wb_clk_i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verilog/wb_mem_top.sv
`timescale 1ns/10ps

module wb_mem_top #(
  parameter int RAM_SIZE_K = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             cmd_req_i,
  input  wb_mem_pkg::cmd_t cmd_i,
  output logic             cmd_ack_o,
  output logic             rsp_req_o,
  output wb_mem_pkg::rsp_t rsp_o,
  input  logic             rsp_ack_i
);

  // command queue
  logic             cq_push, cq_full, cq_pop, cq_empty;
  wb_mem_pkg::cmd_t cq_wdata, cq_head;

  // response queue
  logic             rq_push, rq_full, rq_pop, rq_empty;
  wb_mem_pkg::rsp_t rq_wdata, rq_head;

  // wishbone
  logic                          wb_cyc, wb_stb, wb_we, wb_ack;
  logic [wb_mem_pkg::SEL_W-1:0]  wb_sel;
  logic [wb_mem_pkg::ADDR_W-1:0] wb_adr;
  logic [wb_mem_pkg::DATA_W-1:0] wb_dat_m2s, wb_dat_s2m;

  host_cmd_port i_host_cmd_port (
    .wb_clk_i  (wb_clk_i),   .wb_rst_i  (wb_rst_i),
    .cmd_req_i (cmd_req_i),  .cmd_i     (cmd_i),     .cmd_ack_o (cmd_ack_o),
    .rsp_req_o (rsp_req_o),  .rsp_o     (rsp_o),     .rsp_ack_i (rsp_ack_i),
    .cq_push_o (cq_push),    .cq_data_o (cq_wdata),  .cq_full_i (cq_full),
    .rq_pop_o  (rq_pop),     .rq_data_i (rq_head),   .rq_empty_i(rq_empty)
  );

  //////////////////////////////////////////////////
  // queues
  //////////////////////////////////////////////////

  cmd_fifo #(.payload_t(wb_mem_pkg::cmd_t), .DEPTH(FIFO_DEPTH)) i_cmd_q (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i),
    .push_i   (cq_push),  .data_i   (cq_wdata), .full_o  (cq_full),
    .pop_i    (cq_pop),   .data_o   (cq_head),  .empty_o (cq_empty)
  );

  cmd_fifo #(.payload_t(wb_mem_pkg::rsp_t), .DEPTH(FIFO_DEPTH)) i_rsp_q (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i),
    .push_i   (rq_push),  .data_i   (rq_wdata), .full_o  (rq_full),
    .pop_i    (rq_pop),   .data_o   (rq_head),  .empty_o (rq_empty)
  );

  //////////////////////////////////////////////////
  // bus master and ram
  //////////////////////////////////////////////////

  wb_master i_wb_master (
    .wb_clk_i  (wb_clk_i),   .wb_rst_i  (wb_rst_i),
    .cq_pop_o  (cq_pop),     .cq_data_i (cq_head),   .cq_empty_i (cq_empty),
    .rq_push_o (rq_push),    .rq_data_o (rq_wdata),  .rq_full_i  (rq_full),
    .wb_cyc_o  (wb_cyc),     .wb_stb_o  (wb_stb),    .wb_we_o    (wb_we),
    .wb_sel_o  (wb_sel),     .wb_adr_o  (wb_adr),    .wb_dat_o   (wb_dat_m2s),
    .wb_dat_i  (wb_dat_s2m), .wb_ack_i  (wb_ack)
  );

  bram_controller #(.RAM_SIZE_K(RAM_SIZE_K)) i_bram_controller (
    .wb_clk_i (wb_clk_i),   .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc),     .wb_stb_i (wb_stb),     .wb_we_i  (wb_we),
    .wb_sel_i (wb_sel),     .wb_adr_i (wb_adr),     .wb_dat_i (wb_dat_m2s),
    .wb_dat_o (wb_dat_s2m), .wb_ack_o (wb_ack)
  );

endmodule

//--- verilog/wb_master.sv
`timescale 1ns/10ps

module wb_master (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  // command queue
  output logic                                cq_pop_o,
  input  wb_mem_pkg::cmd_t                    cq_data_i,
  input  logic                                cq_empty_i,
  // response queue
  output logic                                rq_push_o,
  output wb_mem_pkg::rsp_t                    rq_data_o,
  input  logic                                rq_full_i,
  // wishbone master
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [wb_mem_pkg::SEL_W-1:0]        wb_sel_o,
  output logic [wb_mem_pkg::ADDR_W-1:0]       wb_adr_o,
  output logic [wb_mem_pkg::DATA_W-1:0]       wb_dat_o,
  input  logic [wb_mem_pkg::DATA_W-1:0]       wb_dat_i,
  input  logic                                wb_ack_i
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_t;

  state_t           state;
  wb_mem_pkg::cmd_t cur_cmd;           // command in flight

  //////////////////////////////////////////////////
  // command fetch
  //////////////////////////////////////////////////

  // a free response slot guarantees the push at ack
  assign cq_pop_o = (state == ST_IDLE) & ~cq_empty_i & ~rq_full_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (cq_pop_o) state <= ST_BUSY;
        ST_BUSY: if (wb_ack_i) state <= ST_IDLE;   // cyc/stb drop here
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (cq_pop_o) cur_cmd <= cq_data_i;
  end

  // bus cycle straight from the held command
  assign wb_cyc_o = (state == ST_BUSY);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = cur_cmd.write;
  assign wb_sel_o = cur_cmd.sel;
  assign wb_adr_o = cur_cmd.addr;
  assign wb_dat_o = cur_cmd.wdata;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign rq_push_o           = wb_cyc_o & wb_ack_i;
  assign rq_data_o.was_write = cur_cmd.write;
  assign rq_data_o.rdata     = cur_cmd.write ? '0 : wb_dat_i;

endmodule

//--- verilog/host_cmd_port.sv
`timescale 1ns/10ps

module host_cmd_port (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  // host command side
  input  logic             cmd_req_i,
  input  wb_mem_pkg::cmd_t cmd_i,
  output logic             cmd_ack_o,
  // host response side
  output logic             rsp_req_o,
  output wb_mem_pkg::rsp_t rsp_o,
  input  logic             rsp_ack_i,
  // command queue
  output logic             cq_push_o,
  output wb_mem_pkg::cmd_t cq_data_o,
  input  logic             cq_full_i,
  // response queue
  output logic             rq_pop_o,
  input  wb_mem_pkg::rsp_t rq_data_i,
  input  logic             rq_empty_i
);

  typedef enum logic {CMD_IDLE, CMD_ACK} cmd_state_t;
  typedef enum logic [1:0] {RSP_IDLE, RSP_REQ, RSP_DONE} rsp_state_t;

  cmd_state_t cmd_state;
  rsp_state_t rsp_state;

  //////////////////////////////////////////////////
  // command direction
  //////////////////////////////////////////////////

  assign cq_push_o = (cmd_state == CMD_IDLE) & cmd_req_i & ~cq_full_i;
  assign cq_data_o = cmd_i;            // host holds it stable while req is up
  assign cmd_ack_o = (cmd_state == CMD_ACK);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cmd_state <= CMD_IDLE;
    end else begin
      case (cmd_state)
        CMD_IDLE: if (cq_push_o) cmd_state <= CMD_ACK;
        CMD_ACK:  if (!cmd_req_i) cmd_state <= CMD_IDLE;
        default:  cmd_state <= CMD_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // response direction
  //////////////////////////////////////////////////

  assign rsp_req_o = (rsp_state == RSP_REQ);
  assign rsp_o     = rq_data_i;        // head of queue
  assign rq_pop_o  = rsp_req_o & rsp_ack_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rsp_state <= RSP_IDLE;
    end else begin
      case (rsp_state)
        RSP_IDLE: if (!rq_empty_i) rsp_state <= RSP_REQ;
        RSP_REQ:  if (rsp_ack_i) rsp_state <= RSP_DONE;
        // host must drop ack before the next request
        RSP_DONE: if (!rsp_ack_i) rsp_state <= rq_empty_i ? RSP_IDLE : RSP_REQ;
        default:  rsp_state <= RSP_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4         // power of two
) (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  // write side
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  // read side
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];

  // one extra bit tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign data_o = mem[rd_ptr[AW-1:0]];

  //////////////////////////////////////////////////
  // pointers
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge wb_clk_i) begin
    if (push_i) begin
      mem[wr_ptr[AW-1:0]] <= data_i;
    end
  end

endmodule

//--- verilog/bram_controller.sv
`timescale 1ns/10ps

module bram_controller #(
  parameter int RAM_SIZE_K = 8
) (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [wb_mem_pkg::SEL_W-1:0]        wb_sel_i,
  input  logic [wb_mem_pkg::ADDR_W-1:0]       wb_adr_i,
  input  logic [wb_mem_pkg::DATA_W-1:0]       wb_dat_i,
  output logic [wb_mem_pkg::DATA_W-1:0]       wb_dat_o,
  output logic                                wb_ack_o
);

  localparam int NUM_BANKS = (RAM_SIZE_K + 3) / 4;   // one per started 4 KB
  localparam int BANK_IW   = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam int BNUM_W    = wb_mem_pkg::ADDR_W - wb_mem_pkg::BANK_SHIFT;

  function automatic logic [wb_mem_pkg::DATA_W-1:0] bit_rev(
    input logic [wb_mem_pkg::DATA_W-1:0] d
  );
    logic [wb_mem_pkg::DATA_W-1:0] r;
    for (int i = 0; i < wb_mem_pkg::DATA_W; i++) begin
      r[i] = d[wb_mem_pkg::DATA_W-1-i];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // wishbone attach
  //////////////////////////////////////////////////

  logic trans;

  assign trans = wb_cyc_i & wb_stb_i & ~wb_ack_o;   // new access this cycle

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= trans;
    end
  end

  //////////////////////////////////////////////////
  // bank decode
  //////////////////////////////////////////////////

  logic [BNUM_W-1:0]                 bank_num;
  logic                              in_range;
  logic [wb_mem_pkg::SEL_W-1:0]      wr_sel;
  logic [wb_mem_pkg::DATA_W-1:0]     wr_data;
  logic [BANK_IW-1:0]                bank_idx_q;
  logic                              in_range_q;
  logic [wb_mem_pkg::DATA_W-1:0]     bank_rdata [NUM_BANKS];

  assign bank_num = wb_adr_i[wb_mem_pkg::ADDR_W-1:wb_mem_pkg::BANK_SHIFT];
  assign in_range = (bank_num < NUM_BANKS);
  assign wr_sel   = {wb_mem_pkg::SEL_W{wb_we_i & trans}} & wb_sel_i;
  assign wr_data  = bit_rev(wb_dat_i);

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [wb_mem_pkg::SEL_W-1:0] bank_we;

    assign bank_we = (in_range && bank_num[BANK_IW-1:0] == b) ? wr_sel : '0;

    bram_bank i_bram_bank (
      .wb_clk_i (wb_clk_i),
      .we_i     (bank_we),
      .addr_i   (wb_adr_i[wb_mem_pkg::BANK_AW:1]),
      .data_i   (wr_data),
      .data_o   (bank_rdata[b])
    );
  end

  // lines up with the registered bank read
  always_ff @(posedge wb_clk_i) begin
    bank_idx_q <= bank_num[BANK_IW-1:0];
    in_range_q <= in_range;
  end

  assign wb_dat_o = in_range_q ? bit_rev(bank_rdata[bank_idx_q]) : '0;

endmodule

//--- verilog/bram_bank.sv
`timescale 1ns/10ps

module bram_bank (
  input  logic                                wb_clk_i,
  input  logic [1:0]                          we_i,     // byte enables
  input  logic [wb_mem_pkg::BANK_AW-1:0]      addr_i,
  input  logic [wb_mem_pkg::DATA_W-1:0]       data_i,
  output logic [wb_mem_pkg::DATA_W-1:0]       data_o
);

  localparam int WORDS = 1 << wb_mem_pkg::BANK_AW;

  logic [wb_mem_pkg::DATA_W-1:0] mem [WORDS];

  always_ff @(posedge wb_clk_i) begin
    if (we_i[0]) mem[addr_i][7:0]  <= data_i[7:0];
    if (we_i[1]) mem[addr_i][15:8] <= data_i[15:8];
  end

  // write first: a written lane shows the new byte
  always_ff @(posedge wb_clk_i) begin
    data_o[7:0]  <= we_i[0] ? data_i[7:0]  : mem[addr_i][7:0];
    data_o[15:8] <= we_i[1] ? data_i[15:8] : mem[addr_i][15:8];
  end

endmodule

//--- verilog/wb_mem_pkg.sv
package wb_mem_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  localparam int DATA_W = 16;      // wishbone data word
  localparam int SEL_W  = 2;       // one select line per byte
  localparam int ADDR_W = 32;      // byte address

  //////////////////////////////////////////////////
  // bank geometry
  //////////////////////////////////////////////////

  localparam int BANK_AW    = 11;  // 2048 words per bank
  localparam int BANK_SHIFT = 12;  // bank number starts here

  // host command, 51 bits
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] wdata;
  } cmd_t;

  // host response, 17 bits
  typedef struct packed {
    logic              was_write;
    logic [DATA_W-1:0] rdata;      // zero for writes
  } rsp_t;

endpackage
